// ==== rtl/cpu_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// widths are fixed here and are not meant to vary per instance
// opcode values are shared by the ALU and the checker's reference model
//////////////////////////////////////////////////////////////////////

package cpu_pkg;

	//////////////////////////////////////////////////////////////////////
	// widths with a meaning

	// operand or result word
	typedef logic [31:0] data_t;

	// register number, x0 to x31
	typedef logic [4:0] reg_addr_t;

	// instruction address
	typedef logic [31:0] pc_t;

	// architectural register count, x0 included
	localparam int NUM_REGS = 32;

	//////////////////////////////////////////////////////////////////////
	// ALU operations

	typedef logic [2:0] alu_op_t;

	localparam alu_op_t OP_ADD = 3'd0;
	localparam alu_op_t OP_SUB = 3'd1;
	localparam alu_op_t OP_AND = 3'd2;
	localparam alu_op_t OP_OR  = 3'd3;
	localparam alu_op_t OP_XOR = 3'd4;
	localparam alu_op_t OP_SLL = 3'd5;
	localparam alu_op_t OP_SRL = 3'd6;
	// result only from MEM onward
	localparam alu_op_t OP_MUL = 3'd7;

	// where an issuing operand is taken from
	typedef enum logic [1:0] {
		FWD_RF,
		FWD_EXE,
		FWD_MEM,
		FWD_WB
	} fwd_src_t;

endpackage

// ==== rtl/exe_stage.sv ====
//////////////////////////////////////////////////////////////////////
// mul results are not produced here, exe_data_valid is low for a mul
// and the operands move on to MEM for the product
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module exe_stage (
	input  logic               clk,
	input  logic               arst_n,

	// from issue
	input  logic               iss_valid,
	input  cpu_pkg::pc_t       iss_pc,
	input  cpu_pkg::alu_op_t   iss_op,
	input  cpu_pkg::reg_addr_t iss_rd,
	input  logic               iss_wen,
	input  cpu_pkg::data_t     iss_opa,
	input  cpu_pkg::data_t     iss_opb,

	// towards MEM and back to issue
	output logic               exe_valid,
	output cpu_pkg::pc_t       exe_pc,
	output cpu_pkg::reg_addr_t exe_rd,
	output logic               exe_wen,
	output logic               exe_data_valid,
	output cpu_pkg::data_t     exe_data,
	output logic               exe_is_mul,
	output cpu_pkg::data_t     exe_opa,
	output cpu_pkg::data_t     exe_opb
);

	cpu_pkg::alu_op_t op_q;
	logic             wen_q;

	// stage valid, a bubble when issue stalls
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			exe_valid <= 1'b0;
		end
		else
		begin
			exe_valid <= iss_valid;
		end
	end

	// payload
	always_ff @(posedge clk)
	begin
		exe_pc  <= iss_pc;
		op_q    <= iss_op;
		exe_rd  <= iss_rd;
		wen_q   <= iss_wen;
		exe_opa <= iss_opa;
		exe_opb <= iss_opb;
	end

	//////////////////////////////////////////////////////////////////////
	// ALU

	always_comb
	begin
		case (op_q)
			cpu_pkg::OP_ADD: exe_data = exe_opa + exe_opb;
			cpu_pkg::OP_SUB: exe_data = exe_opa - exe_opb;
			cpu_pkg::OP_AND: exe_data = exe_opa & exe_opb;
			cpu_pkg::OP_OR:  exe_data = exe_opa | exe_opb;
			cpu_pkg::OP_XOR: exe_data = exe_opa ^ exe_opb;
			// shift amount from the low 5 bits
			cpu_pkg::OP_SLL: exe_data = exe_opa << exe_opb[4:0];
			cpu_pkg::OP_SRL: exe_data = exe_opa >> exe_opb[4:0];
			// product formed in MEM
			default:         exe_data = '0;
		endcase
	end

	assign exe_is_mul     = (op_q == cpu_pkg::OP_MUL);
	assign exe_data_valid = !exe_is_mul;

	// write info seen by wake_up only for a live instruction
	assign exe_wen = exe_valid && wen_q;

endmodule

// ==== rtl/issue_stage.sv ====
//////////////////////////////////////////////////////////////////////
// holds one instruction, stalls until wake_up reports both operands ready
// the source must hold its fields while in_valid is high and in_ready low
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module issue_stage (
	input  logic               clk,
	input  logic               arst_n,

	// instruction entry
	input  logic               in_valid,
	input  cpu_pkg::pc_t       in_pc,
	input  cpu_pkg::alu_op_t   in_op,
	input  logic               in_src1_is_reg,
	input  logic               in_src2_is_reg,
	input  cpu_pkg::reg_addr_t in_rs1,
	input  cpu_pkg::reg_addr_t in_rs2,
	input  cpu_pkg::reg_addr_t in_rd,
	input  logic               in_wen,
	input  cpu_pkg::data_t     in_imm,
	output logic               in_ready,

	// later stage write info
	input  cpu_pkg::reg_addr_t exe_rd,
	input  logic               exe_wen,
	input  logic               exe_data_valid,
	input  cpu_pkg::data_t     exe_data,
	input  cpu_pkg::reg_addr_t mem_rd,
	input  logic               mem_wen,
	input  cpu_pkg::data_t     mem_data,
	input  cpu_pkg::reg_addr_t wb_rd,
	input  logic               wb_wen,
	input  cpu_pkg::data_t     wb_data,

	// register file write from WB
	input  logic               rf_we,
	input  cpu_pkg::reg_addr_t rf_waddr,
	input  cpu_pkg::data_t     rf_wdata,

	// towards EXE
	output logic               iss_valid,
	output cpu_pkg::pc_t       iss_pc,
	output cpu_pkg::alu_op_t   iss_op,
	output cpu_pkg::reg_addr_t iss_rd,
	output logic               iss_wen,
	output cpu_pkg::data_t     iss_opa,
	output cpu_pkg::data_t     iss_opb
);

	// holding register
	logic               hold_valid;
	cpu_pkg::pc_t       hold_pc;
	cpu_pkg::alu_op_t   hold_op;
	logic               hold_src1_is_reg;
	logic               hold_src2_is_reg;
	cpu_pkg::reg_addr_t hold_rs1;
	cpu_pkg::reg_addr_t hold_rs2;
	cpu_pkg::reg_addr_t hold_rd;
	logic               hold_wen;
	cpu_pkg::data_t     hold_imm;

	// readiness and operand paths
	logic               src1_ready;
	logic               src2_ready;
	cpu_pkg::fwd_src_t  src1_fwd;
	cpu_pkg::fwd_src_t  src2_fwd;
	cpu_pkg::data_t     rf_rdata1;
	cpu_pkg::data_t     rf_rdata2;
	cpu_pkg::data_t     reg1_val;
	cpu_pkg::data_t     reg2_val;
	logic               stall;

	//////////////////////////////////////////////////////////////////////
	// hold and stall control

	// held instruction waits on an operand
	assign stall = hold_valid && !(src1_ready && src2_ready);

	// leaves this cycle, otherwise a bubble goes to EXE
	assign iss_valid = hold_valid && !stall;

	// free slot, or the slot empties at this edge
	assign in_ready = !hold_valid || iss_valid;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			hold_valid <= 1'b0;
		end
		else if (in_ready)
		begin
			hold_valid <= in_valid;
		end
	end

	// payload loads only on a transfer
	always_ff @(posedge clk)
	begin
		if (in_valid && in_ready)
		begin
			hold_pc          <= in_pc;
			hold_op          <= in_op;
			hold_src1_is_reg <= in_src1_is_reg;
			hold_src2_is_reg <= in_src2_is_reg;
			hold_rs1         <= in_rs1;
			hold_rs2         <= in_rs2;
			hold_rd          <= in_rd;
			hold_wen         <= in_wen;
			hold_imm         <= in_imm;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// operand readiness and register read

	wake_up i_wake_up (
		.src1_is_reg    (hold_src1_is_reg),
		.src2_is_reg    (hold_src2_is_reg),
		.rs1            (hold_rs1),
		.rs2            (hold_rs2),
		.exe_rd         (exe_rd),
		.exe_wen        (exe_wen),
		.exe_data_valid (exe_data_valid),
		.mem_rd         (mem_rd),
		.mem_wen        (mem_wen),
		.wb_rd          (wb_rd),
		.wb_wen         (wb_wen),
		.src1_ready     (src1_ready),
		.src2_ready     (src2_ready),
		.src1_fwd       (src1_fwd),
		.src2_fwd       (src2_fwd)
	);

	reg_file i_reg_file (
		.clk    (clk),
		.arst_n (arst_n),
		.raddr1 (hold_rs1),
		.raddr2 (hold_rs2),
		.we     (rf_we),
		.waddr  (rf_waddr),
		.wdata  (rf_wdata),
		.rdata1 (rf_rdata1),
		.rdata2 (rf_rdata2)
	);

	//////////////////////////////////////////////////////////////////////
	// operand muxing

	// follows the source picked by wake_up
	function automatic cpu_pkg::data_t fwd_mux(
		input cpu_pkg::fwd_src_t sel,
		input cpu_pkg::data_t    rf_val
	);
		cpu_pkg::data_t val;
		case (sel)
			cpu_pkg::FWD_EXE: val = exe_data;
			cpu_pkg::FWD_MEM: val = mem_data;
			cpu_pkg::FWD_WB:  val = wb_data;
			default:          val = rf_val;
		endcase
		return val;
	endfunction

	always_comb
	begin
		reg1_val = fwd_mux(src1_fwd, rf_rdata1);
		reg2_val = fwd_mux(src2_fwd, rf_rdata2);
	end

	// operand 1 is pc or register, operand 2 is imm or register
	assign iss_opa = hold_src1_is_reg ? reg1_val : hold_pc;
	assign iss_opb = hold_src2_is_reg ? reg2_val : hold_imm;
	assign iss_pc  = hold_pc;
	assign iss_op  = hold_op;
	assign iss_rd  = hold_rd;
	assign iss_wen = hold_wen;

endmodule

// ==== rtl/mem_wb_stage.sv ====
//////////////////////////////////////////////////////////////////////
// MEM completes the mul, WB drives both writeback and register file write
// write enables are masked by the stage valid
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module mem_wb_stage (
	input  logic               clk,
	input  logic               arst_n,

	// from EXE
	input  logic               exe_valid,
	input  cpu_pkg::pc_t       exe_pc,
	input  cpu_pkg::reg_addr_t exe_rd,
	input  logic               exe_wen,
	input  cpu_pkg::data_t     exe_data,
	input  logic               exe_is_mul,
	input  cpu_pkg::data_t     exe_opa,
	input  cpu_pkg::data_t     exe_opb,

	// MEM write info
	output cpu_pkg::reg_addr_t mem_rd,
	output logic               mem_wen,
	output cpu_pkg::data_t     mem_data,

	// writeback
	output logic               wb_valid,
	output cpu_pkg::pc_t       wb_pc,
	output cpu_pkg::reg_addr_t wb_rd,
	output logic               wb_wen,
	output cpu_pkg::data_t     wb_data
);

	logic           mem_valid;
	cpu_pkg::pc_t   mem_pc;
	logic           mem_wen_q;
	logic           wb_wen_q;
	cpu_pkg::data_t product;

	// 32-bit context keeps only the low half of the product
	assign product = exe_opa * exe_opb;

	//////////////////////////////////////////////////////////////////////
	// stage valids

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			mem_valid <= 1'b0;
			wb_valid  <= 1'b0;
		end
		else
		begin
			mem_valid <= exe_valid;
			wb_valid  <= mem_valid;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// payload

	always_ff @(posedge clk)
	begin
		// MEM
		mem_pc    <= exe_pc;
		mem_rd    <= exe_rd;
		mem_wen_q <= exe_wen;
		mem_data  <= exe_is_mul ? product : exe_data;
		// WB
		wb_pc     <= mem_pc;
		wb_rd     <= mem_rd;
		wb_wen_q  <= mem_wen;
		wb_data   <= mem_data;
	end

	assign mem_wen = mem_valid && mem_wen_q;
	assign wb_wen  = wb_valid && wb_wen_q;

endmodule

// ==== rtl/pipe_top.sv ====
//////////////////////////////////////////////////////////////////////
// writeback has no ready, the consumer must take every wb_valid pulse
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module pipe_top (
	input  logic               clk,
	input  logic               arst_n,

	// instruction entry
	input  logic               in_valid,
	input  cpu_pkg::pc_t       in_pc,
	input  cpu_pkg::alu_op_t   in_op,
	input  logic               in_src1_is_reg,
	input  logic               in_src2_is_reg,
	input  cpu_pkg::reg_addr_t in_rs1,
	input  cpu_pkg::reg_addr_t in_rs2,
	input  cpu_pkg::reg_addr_t in_rd,
	input  logic               in_wen,
	input  cpu_pkg::data_t     in_imm,
	output logic               in_ready,

	// writeback
	output logic               wb_valid,
	output cpu_pkg::pc_t       wb_pc,
	output cpu_pkg::reg_addr_t wb_rd,
	output logic               wb_wen,
	output cpu_pkg::data_t     wb_data
);

	// issue to EXE
	logic               iss_valid;
	cpu_pkg::pc_t       iss_pc;
	cpu_pkg::alu_op_t   iss_op;
	cpu_pkg::reg_addr_t iss_rd;
	logic               iss_wen;
	cpu_pkg::data_t     iss_opa;
	cpu_pkg::data_t     iss_opb;

	// EXE to MEM
	logic               exe_valid;
	cpu_pkg::pc_t       exe_pc;
	cpu_pkg::reg_addr_t exe_rd;
	logic               exe_wen;
	logic               exe_data_valid;
	cpu_pkg::data_t     exe_data;
	logic               exe_is_mul;
	cpu_pkg::data_t     exe_opa;
	cpu_pkg::data_t     exe_opb;

	// MEM write info
	cpu_pkg::reg_addr_t mem_rd;
	logic               mem_wen;
	cpu_pkg::data_t     mem_data;

	// WB register doubles as the register file write
	issue_stage i_issue_stage (
		.clk            (clk),
		.arst_n         (arst_n),
		.in_valid       (in_valid),
		.in_pc          (in_pc),
		.in_op          (in_op),
		.in_src1_is_reg (in_src1_is_reg),
		.in_src2_is_reg (in_src2_is_reg),
		.in_rs1         (in_rs1),
		.in_rs2         (in_rs2),
		.in_rd          (in_rd),
		.in_wen         (in_wen),
		.in_imm         (in_imm),
		.in_ready       (in_ready),
		.exe_rd         (exe_rd),
		.exe_wen        (exe_wen),
		.exe_data_valid (exe_data_valid),
		.exe_data       (exe_data),
		.mem_rd         (mem_rd),
		.mem_wen        (mem_wen),
		.mem_data       (mem_data),
		.wb_rd          (wb_rd),
		.wb_wen         (wb_wen),
		.wb_data        (wb_data),
		.rf_we          (wb_wen),
		.rf_waddr       (wb_rd),
		.rf_wdata       (wb_data),
		.iss_valid      (iss_valid),
		.iss_pc         (iss_pc),
		.iss_op         (iss_op),
		.iss_rd         (iss_rd),
		.iss_wen        (iss_wen),
		.iss_opa        (iss_opa),
		.iss_opb        (iss_opb)
	);

	exe_stage i_exe_stage (
		.clk            (clk),
		.arst_n         (arst_n),
		.iss_valid      (iss_valid),
		.iss_pc         (iss_pc),
		.iss_op         (iss_op),
		.iss_rd         (iss_rd),
		.iss_wen        (iss_wen),
		.iss_opa        (iss_opa),
		.iss_opb        (iss_opb),
		.exe_valid      (exe_valid),
		.exe_pc         (exe_pc),
		.exe_rd         (exe_rd),
		.exe_wen        (exe_wen),
		.exe_data_valid (exe_data_valid),
		.exe_data       (exe_data),
		.exe_is_mul     (exe_is_mul),
		.exe_opa        (exe_opa),
		.exe_opb        (exe_opb)
	);

	mem_wb_stage i_mem_wb_stage (
		.clk        (clk),
		.arst_n     (arst_n),
		.exe_valid  (exe_valid),
		.exe_pc     (exe_pc),
		.exe_rd     (exe_rd),
		.exe_wen    (exe_wen),
		.exe_data   (exe_data),
		.exe_is_mul (exe_is_mul),
		.exe_opa    (exe_opa),
		.exe_opb    (exe_opb),
		.mem_rd     (mem_rd),
		.mem_wen    (mem_wen),
		.mem_data   (mem_data),
		.wb_valid   (wb_valid),
		.wb_pc      (wb_pc),
		.wb_rd      (wb_rd),
		.wb_wen     (wb_wen),
		.wb_data    (wb_data)
	);

endmodule

// ==== rtl/reg_file.sv ====
//////////////////////////////////////////////////////////////////////
// reads are asynchronous, a same-cycle write is not seen by a read
// x0 reads zero and ignores writes
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module reg_file (
	input  logic               clk,
	input  logic               arst_n,
	input  cpu_pkg::reg_addr_t raddr1,
	input  cpu_pkg::reg_addr_t raddr2,
	input  logic               we,
	input  cpu_pkg::reg_addr_t waddr,
	input  cpu_pkg::data_t     wdata,
	output cpu_pkg::data_t     rdata1,
	output cpu_pkg::data_t     rdata2
);

	// entry 0 stays at its reset value and is never read
	cpu_pkg::data_t regs [cpu_pkg::NUM_REGS];

	// write port, x0 discarded
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < cpu_pkg::NUM_REGS; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (we && waddr != '0)
		begin
			regs[waddr] <= wdata;
		end
	end

	// read ports
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

// ==== rtl/wake_up.sv ====
//////////////////////////////////////////////////////////////////////
// purely combinational, no clock
// stage write enables must already be gated by their stage valid
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module wake_up (
	// operand selects and source registers of the held instruction
	input  logic               src1_is_reg,
	input  logic               src2_is_reg,
	input  cpu_pkg::reg_addr_t rs1,
	input  cpu_pkg::reg_addr_t rs2,

	// write info of the later stages
	input  cpu_pkg::reg_addr_t exe_rd,
	input  logic               exe_wen,
	input  logic               exe_data_valid,
	input  cpu_pkg::reg_addr_t mem_rd,
	input  logic               mem_wen,
	input  cpu_pkg::reg_addr_t wb_rd,
	input  logic               wb_wen,

	// readiness and forwarding choice per operand
	output logic               src1_ready,
	output logic               src2_ready,
	output cpu_pkg::fwd_src_t  src1_fwd,
	output cpu_pkg::fwd_src_t  src2_fwd
);

	//////////////////////////////////////////////////////////////////////
	// source selection

	// youngest writer wins, EXE is the youngest
	// x0 and pc or imm operands always take the register file path
	function automatic cpu_pkg::fwd_src_t pick_src(
		input logic               is_reg,
		input cpu_pkg::reg_addr_t rs
	);
		cpu_pkg::fwd_src_t src;
		src = cpu_pkg::FWD_RF;
		if (is_reg && rs != '0)
		begin
			if (exe_wen && rs == exe_rd)
			begin
				src = cpu_pkg::FWD_EXE;
			end
			else if (mem_wen && rs == mem_rd)
			begin
				src = cpu_pkg::FWD_MEM;
			end
			else if (wb_wen && rs == wb_rd)
			begin
				src = cpu_pkg::FWD_WB;
			end
		end
		return src;
	endfunction

	always_comb
	begin
		src1_fwd = pick_src(src1_is_reg, rs1);
		src2_fwd = pick_src(src2_is_reg, rs2);
	end

	//////////////////////////////////////////////////////////////////////
	// readiness

	// only an EXE writer without its result yet (a mul) blocks
	// MEM and WB data always exist
	always_comb
	begin
		src1_ready = (src1_fwd != cpu_pkg::FWD_EXE) || exe_data_valid;
		src2_ready = (src2_fwd != cpu_pkg::FWD_EXE) || exe_data_valid;
	end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_top \
	-f verilog.f \
	-o sim_tb_top

./obj_dir/sim_tb_top | tee sim.log

if grep -q "Test FAILED" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"

// ==== testbench/pipe_assert.sv ====
//////////////////////////////////////////////////////////////////////
// bound into issue_stage, sees its holding register and the EXE write info
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module pipe_assert (
	input logic               clk,
	input logic               arst_n,
	input logic               stall,
	input logic               hold_valid,
	input logic               in_ready,
	input logic               iss_valid,
	input logic               hold_src1_is_reg,
	input logic               hold_src2_is_reg,
	input cpu_pkg::reg_addr_t hold_rs1,
	input cpu_pkg::reg_addr_t hold_rs2,
	input cpu_pkg::reg_addr_t exe_rd,
	input logic               exe_wen,
	input logic               exe_data_valid
);

	// register source whose youngest writer is a mul still in EXE
	logic src1_waits;
	logic src2_waits;

	assign src1_waits = hold_src1_is_reg && hold_rs1 != '0 && exe_wen
		&& !exe_data_valid && hold_rs1 == exe_rd;
	assign src2_waits = hold_src2_is_reg && hold_rs2 != '0 && exe_wen
		&& !exe_data_valid && hold_rs2 == exe_rd;

	// only a mul in EXE stalls, and it moves to MEM behind a bubble
	stall_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
		stall |=> !stall)
		else $error("issue stall lasted more than one cycle");

	// back-pressure only from a held instruction waiting on a mul
	ready_low_needs_hold: assert property (@(posedge clk) disable iff (!arst_n)
		!in_ready |-> (hold_valid && (src1_waits || src2_waits)))
		else $error("in_ready low without a held instruction waiting on a mul");

	// no issue with an operand still missing
	issue_needs_operands: assert property (@(posedge clk) disable iff (!arst_n)
		iss_valid |-> !(src1_waits || src2_waits))
		else $error("instruction issued with an unready operand");

endmodule

// ==== testbench/tb_checker.sv ====
//////////////////////////////////////////////////////////////////////
// shadow register file starts at zero, matching the DUT reset
// assumes one reset at the start of the run only
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_checker (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               in_valid,
	input  logic               in_ready,
	input  cpu_pkg::pc_t       in_pc,
	input  cpu_pkg::alu_op_t   in_op,
	input  logic               in_src1_is_reg,
	input  logic               in_src2_is_reg,
	input  cpu_pkg::reg_addr_t in_rs1,
	input  cpu_pkg::reg_addr_t in_rs2,
	input  cpu_pkg::reg_addr_t in_rd,
	input  logic               in_wen,
	input  cpu_pkg::data_t     in_imm,
	input  logic               wb_valid,
	input  cpu_pkg::pc_t       wb_pc,
	input  cpu_pkg::reg_addr_t wb_rd,
	input  logic               wb_wen,
	input  cpu_pkg::data_t     wb_data,
	input  logic               run_done,
	input  int                 expected_total,
	output int                 error_count,
	output int                 wb_count,
	output int                 accepted_count
);

	typedef struct packed {
		cpu_pkg::pc_t       pc;
		cpu_pkg::alu_op_t   op;
		logic               src1_is_reg;
		logic               src2_is_reg;
		cpu_pkg::reg_addr_t rs1;
		cpu_pkg::reg_addr_t rs2;
		cpu_pkg::reg_addr_t rd;
		logic               wen;
		cpu_pkg::data_t     imm;
	} instr_t;

	// accepted and not yet written back, oldest first
	instr_t         pending_q [$];
	cpu_pkg::data_t shadow [cpu_pkg::NUM_REGS];
	int             errors   = 0;
	int             wbs      = 0;
	int             accepted = 0;
	logic           end_checked = 1'b0;

	assign error_count    = errors;
	assign wb_count       = wbs;
	assign accepted_count = accepted;

	initial
	begin
		for (int i = 0; i < cpu_pkg::NUM_REGS; i++)
			shadow[i] = '0;
	end

	// expected ALU result, product truncated to 32 bits
	function automatic cpu_pkg::data_t ref_alu(
		input cpu_pkg::alu_op_t op,
		input cpu_pkg::data_t   a,
		input cpu_pkg::data_t   b
	);
		cpu_pkg::data_t r;
		case (op)
			cpu_pkg::OP_ADD: r = a + b;
			cpu_pkg::OP_SUB: r = a - b;
			cpu_pkg::OP_AND: r = a & b;
			cpu_pkg::OP_OR:  r = a | b;
			cpu_pkg::OP_XOR: r = a ^ b;
			cpu_pkg::OP_SLL: r = a << b[4:0];
			cpu_pkg::OP_SRL: r = a >> b[4:0];
			default:         r = a * b;
		endcase
		return r;
	endfunction

	// compare one writeback, then retire it into the shadow file
	task automatic check_writeback(input instr_t rec);
		cpu_pkg::data_t opa;
		cpu_pkg::data_t opb;
		cpu_pkg::data_t exp_data;
		opa      = rec.src1_is_reg ? shadow[rec.rs1] : rec.pc;
		opb      = rec.src2_is_reg ? shadow[rec.rs2] : rec.imm;
		exp_data = ref_alu(rec.op, opa, opb);
		if (wb_pc !== rec.pc || wb_rd !== rec.rd || wb_wen !== rec.wen)
		begin
			$display("ERROR %0t: writeback pc %h rd %0d wen %b, expected pc %h rd %0d wen %b",
				$time, wb_pc, wb_rd, wb_wen, rec.pc, rec.rd, rec.wen);
			errors++;
		end
		if (wb_data !== exp_data)
		begin
			$display("ERROR %0t: pc %h op %0d data %h, expected %h",
				$time, rec.pc, rec.op, wb_data, exp_data);
			errors++;
		end
		// x0 writes discarded
		if (rec.wen && rec.rd != '0)
			shadow[rec.rd] = exp_data;
	endtask

	always @(posedge clk)
	begin
		if (arst_n)
		begin
			// state right after reset
			if (accepted == 0 && (!in_ready || wb_valid))
			begin
				$display("before the first transfer in_ready was low or wb_valid was high");
				errors++;
			end
			// writeback before entry, latency is at least 3
			if (wb_valid)
			begin
				wbs++;
				if (pending_q.size() == 0)
				begin
					$display("writeback at pc %h with no accepted instruction left", wb_pc);
					errors++;
				end
				else
					check_writeback(pending_q.pop_front());
			end
			if (in_valid && in_ready)
			begin
				pending_q.push_back({in_pc, in_op, in_src1_is_reg, in_src2_is_reg,
					in_rs1, in_rs2, in_rd, in_wen, in_imm});
				accepted++;
			end
			// final bookkeeping, once
			if (run_done && !end_checked)
			begin
				end_checked = 1'b1;
				if (pending_q.size() != 0 || accepted != expected_total)
				begin
					$display("%0d instructions never wrote back, %0d of %0d accepted",
						pending_q.size(), accepted, expected_total);
					errors++;
				end
			end
		end
	end

endmodule

// ==== testbench/tb_top.sv ====
//////////////////////////////////////////////////////////////////////
// random stream over x0 to x5 keeps dependencies dense
// the run length is fixed by NUM_INSTR, and the watchdog scales with it
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_top;

	localparam int NUM_INSTR       = 2000;
	localparam int CLK_PERIOD      = 8;
	localparam int RESET_CYCLES    = 10;
	localparam int WATCHDOG_CYCLES = NUM_INSTR * 4 + 200;

	logic               clk;
	logic               arst_n;
	logic               in_valid;
	cpu_pkg::pc_t       in_pc;
	cpu_pkg::alu_op_t   in_op;
	logic               in_src1_is_reg;
	logic               in_src2_is_reg;
	cpu_pkg::reg_addr_t in_rs1;
	cpu_pkg::reg_addr_t in_rs2;
	cpu_pkg::reg_addr_t in_rd;
	logic               in_wen;
	cpu_pkg::data_t     in_imm;
	logic               in_ready;
	logic               wb_valid;
	cpu_pkg::pc_t       wb_pc;
	cpu_pkg::reg_addr_t wb_rd;
	logic               wb_wen;
	cpu_pkg::data_t     wb_data;
	logic               run_done;
	int                 error_count;
	int                 wb_count;
	int                 accepted_count;
	cpu_pkg::pc_t       next_pc;

	pipe_top i_pipe_top (
		.clk            (clk),
		.arst_n         (arst_n),
		.in_valid       (in_valid),
		.in_pc          (in_pc),
		.in_op          (in_op),
		.in_src1_is_reg (in_src1_is_reg),
		.in_src2_is_reg (in_src2_is_reg),
		.in_rs1         (in_rs1),
		.in_rs2         (in_rs2),
		.in_rd          (in_rd),
		.in_wen         (in_wen),
		.in_imm         (in_imm),
		.in_ready       (in_ready),
		.wb_valid       (wb_valid),
		.wb_pc          (wb_pc),
		.wb_rd          (wb_rd),
		.wb_wen         (wb_wen),
		.wb_data        (wb_data)
	);

	// watches entry and writeback, keeps the shadow model
	tb_checker i_tb_checker (
		.clk            (clk),
		.arst_n         (arst_n),
		.in_valid       (in_valid),
		.in_ready       (in_ready),
		.in_pc          (in_pc),
		.in_op          (in_op),
		.in_src1_is_reg (in_src1_is_reg),
		.in_src2_is_reg (in_src2_is_reg),
		.in_rs1         (in_rs1),
		.in_rs2         (in_rs2),
		.in_rd          (in_rd),
		.in_wen         (in_wen),
		.in_imm         (in_imm),
		.wb_valid       (wb_valid),
		.wb_pc          (wb_pc),
		.wb_rd          (wb_rd),
		.wb_wen         (wb_wen),
		.wb_data        (wb_data),
		.run_done       (run_done),
		.expected_total (NUM_INSTR),
		.error_count    (error_count),
		.wb_count       (wb_count),
		.accepted_count (accepted_count)
	);

	// stall and ready properties on the issue holding register
	bind issue_stage pipe_assert i_pipe_assert (
		.clk              (clk),
		.arst_n           (arst_n),
		.stall            (stall),
		.hold_valid       (hold_valid),
		.in_ready         (in_ready),
		.iss_valid        (iss_valid),
		.hold_src1_is_reg (hold_src1_is_reg),
		.hold_src2_is_reg (hold_src2_is_reg),
		.hold_rs1         (hold_rs1),
		.hold_rs2         (hold_rs2),
		.exe_rd           (exe_rd),
		.exe_wen          (exe_wen),
		.exe_data_valid   (exe_data_valid)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// register number from x0 to x5
	function automatic cpu_pkg::reg_addr_t pick_reg();
		logic [31:0] r;
		r = $urandom % 6;
		return r[4:0];
	endfunction

	// present one random instruction and hold it until accepted
	task automatic send_random_instr(input cpu_pkg::pc_t pc);
		logic [31:0] r;
		r = $urandom;
		in_valid       <= 1'b1;
		in_pc          <= pc;
		in_op          <= r[2:0];
		in_src1_is_reg <= ($urandom % 4) != 0;
		in_src2_is_reg <= ($urandom % 2) != 0;
		in_rs1         <= pick_reg();
		in_rs2         <= pick_reg();
		in_rd          <= pick_reg();
		in_wen         <= ($urandom % 8) != 0;
		in_imm         <= $urandom;
		do
			@(posedge clk);
		while (!in_ready);
	endtask

	//////////////////////////////////////////////////////////////////////
	// stimulus and closing

	initial
	begin
		void'($urandom(32'h68f554eb));
		arst_n         = 1'b0;
		run_done       = 1'b0;
		in_valid       = 1'b0;
		in_pc          = '0;
		in_op          = cpu_pkg::OP_ADD;
		in_src1_is_reg = 1'b0;
		in_src2_is_reg = 1'b0;
		in_rs1         = '0;
		in_rs2         = '0;
		in_rd          = '0;
		in_wen         = 1'b0;
		in_imm         = '0;
		next_pc        = 32'h0000_1000;
		repeat (RESET_CYCLES) @(posedge clk);
		arst_n <= 1'b1;
		// a few idle edges so the post-reset state is observed
		repeat (3) @(posedge clk);
		for (int n = 0; n < NUM_INSTR; n++)
		begin
			// occasional idle cycle on the entry
			if (($urandom % 5) == 0)
			begin
				in_valid <= 1'b0;
				@(posedge clk);
			end
			send_random_instr(next_pc);
			next_pc = next_pc + 32'd4;
		end
		in_valid <= 1'b0;
		// drain, then some edges to catch stray writebacks
		while (wb_count < NUM_INSTR)
			@(posedge clk);
		repeat (8) @(posedge clk);
		run_done <= 1'b1;
		repeat (3) @(posedge clk);
		$display("errors: %0d, accepted: %0d, writebacks: %0d",
			error_count, accepted_count, wb_count);
		if (error_count == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	// watchdog
	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("the run hung: writebacks still missing when the watchdog expired");
		$display("errors: %0d, accepted: %0d, writebacks: %0d",
			error_count, accepted_count, wb_count);
		$display("Test FAILED");
		$finish;
	end

endmodule

// ==== verilog.f ====
rtl/cpu_pkg.sv
rtl/wake_up.sv
rtl/reg_file.sv
rtl/issue_stage.sv
rtl/exe_stage.sv
rtl/mem_wb_stage.sv
rtl/pipe_top.sv
testbench/pipe_assert.sv
testbench/tb_checker.sv
testbench/tb_top.sv
